/* source/tmip_pkg.sv */
`default_nettype none

package tmip_pkg;

  // ------------------------------------------------------------------------
  // constants
  // ------------------------------------------------------------------------
  localparam int corr_bits = 20;
  localparam int act_max = 8;

  // ------------------------------------------------------------------------
  // data types
  // ------------------------------------------------------------------------
  typedef logic [7:0] pixel_t;
  typedef logic [corr_bits-1:0] corr_t;

  // template slots in raster order, slot 0 is the top left tap
  typedef pixel_t [8:0] tmpl_t;

  typedef struct packed {
    pixel_t max_val;
    pixel_t avg_val;
    pixel_t wgt_val;
  } gray_triple_t;

  typedef enum logic [1:0] {
    gray_max = 2'd0,
    gray_avg = 2'd1,
    gray_wgt = 2'd2
  } gray_method_e;

  // codes 3 and 6 are kept in the list but do nothing
  typedef enum logic [2:0] {
    act_maxp_nop = 3'd3,
    act_neg      = 3'd4,
    act_hori     = 3'd5,
    act_medf_nop = 3'd6,
    act_xcorr    = 3'd7
  } action_e;

  typedef struct packed {
    logic         load;
    logic         neg;
    logic         flip;
    gray_method_e method;
  } frame_op_t;

endpackage

`default_nettype wire

/* source/tmip_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module tmip_capture #(
  parameter int img_dim = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 in_valid,
  input  tmip_pkg::pixel_t                     image,
  input  tmip_pkg::pixel_t                     template,
  output logic                                 pix_wr,
  output logic [$clog2(img_dim*img_dim)-1:0]   pix_addr,
  output tmip_pkg::gray_triple_t               pix_gray,
  output tmip_pkg::tmpl_t                      tmpl
);

  localparam int addr_w = $clog2(img_dim*img_dim);

  // 0 = R byte, 1 = G byte, 2 = B byte
  logic [1:0]             phase;
  logic [addr_w-1:0]      pix_cnt;
  logic [3:0]             tmpl_cnt;
  tmip_pkg::pixel_t       r_q;
  tmip_pkg::pixel_t       g_q;
  tmip_pkg::pixel_t       max_rg;
  logic [9:0]             rgb_sum;
  tmip_pkg::gray_triple_t gray_now;
  logic                   b_byte;

  assign b_byte = in_valid && (phase == 2'd2);

  // ------------------------------------------------------------------------
  // grey values, B taken straight from the input byte
  // ------------------------------------------------------------------------
  always_comb
  begin
    max_rg = (r_q > g_q) ? r_q : g_q;
    gray_now.max_val = (max_rg > image) ? max_rg : image;
    rgb_sum = {2'b00, r_q} + {2'b00, g_q} + {2'b00, image};
    gray_now.avg_val = tmip_pkg::pixel_t'(rgb_sum / 10'd3);
    // worst case 63 + 127 + 63 still fits in a byte
    gray_now.wgt_val = (r_q >> 2) + (g_q >> 1) + (image >> 2);
  end

  // ------------------------------------------------------------------------
  // byte counters
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase    <= 2'd0;
      pix_cnt  <= '0;
      tmpl_cnt <= 4'd0;
      pix_wr   <= 1'b0;
    end
    else
    begin
      pix_wr <= b_byte;
      if (in_valid)
      begin
        phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
        if (b_byte)
        begin
          pix_cnt <= pix_cnt + 1'b1;
        end
        if (tmpl_cnt < 4'd9)
        begin
          tmpl_cnt <= tmpl_cnt + 4'd1;
        end
      end
      else
      begin
        // idle between frames, next frame starts from slot 0
        phase    <= 2'd0;
        pix_cnt  <= '0;
        tmpl_cnt <= 4'd0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_valid && phase == 2'd0)
    begin
      r_q <= image;
    end
    if (in_valid && phase == 2'd1)
    begin
      g_q <= image;
    end
    if (b_byte)
    begin
      pix_gray <= gray_now;
      pix_addr <= pix_cnt;
    end
    if (in_valid && tmpl_cnt < 4'd9)
    begin
      tmpl[tmpl_cnt] <= template;
    end
  end

  // the stream must end on a B byte
  a_whole_pixels: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(in_valid) |-> phase == 2'd0);

endmodule

`default_nettype wire

/* source/tmip_action_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module tmip_action_seq (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid2,
  input  logic [2:0]          action,
  input  logic                xcorr_done,
  output tmip_pkg::frame_op_t frame_op,
  output logic                xcorr_start
);

  localparam int idx_w = $clog2(tmip_pkg::act_max);

  typedef enum logic [1:0] {
    st_input,
    st_load,
    st_run,
    st_xcorr
  } seq_state_e;

  seq_state_e        state;
  logic [idx_w:0]    cnt;
  logic [idx_w-1:0]  idx;
  logic [2:0]        act_buf [tmip_pkg::act_max];
  tmip_pkg::action_e cur_act;
  logic              last_entry;

  assign cur_act = tmip_pkg::action_e'(act_buf[idx]);
  assign last_entry = ({1'b0, idx} + 1'b1) == cnt;

  // action list, entry 0 holds the grey method
  always_ff @(posedge clk)
  begin
    if (in_valid2)
    begin
      act_buf[cnt[idx_w-1:0]] <= action;
    end
  end

  // ------------------------------------------------------------------------
  // sequencer
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= st_input;
      cnt   <= '0;
      idx   <= '0;
    end
    else
    begin
      case (state)
        st_input:
        begin
          if (in_valid2)
          begin
            cnt <= cnt + 1'b1;
          end
          else if (cnt != '0)
          begin
            state <= st_load;
          end
        end
        st_load:
        begin
          idx   <= idx_w'(1);
          state <= st_run;
        end
        st_run:
        begin
          if (cur_act == tmip_pkg::act_xcorr)
          begin
            state <= st_xcorr;
          end
          else if (last_entry)
          begin
            // list ran out without a correlation
            state <= st_input;
            cnt   <= '0;
          end
          else
          begin
            idx <= idx + 1'b1;
          end
        end
        default:
        begin
          if (xcorr_done)
          begin
            state <= st_input;
            cnt   <= '0;
          end
        end
      endcase
    end
  end

  // one strobe per cycle, decoded from the current entry
  always_comb
  begin
    frame_op = '0;
    frame_op.method = tmip_pkg::gray_method_e'(act_buf[0][1:0]);
    xcorr_start = 1'b0;
    case (state)
      st_load:
      begin
        frame_op.load = 1'b1;
      end
      st_run:
      begin
        case (cur_act)
          tmip_pkg::act_neg:
            frame_op.neg = 1'b1;
          tmip_pkg::act_hori:
            frame_op.flip = 1'b1;
          tmip_pkg::act_xcorr:
            xcorr_start = 1'b1;
          default:
            ;
        endcase
      end
      default:
        ;
    endcase
  end

  a_list_len: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid2 |-> state == st_input && int'(cnt) < tmip_pkg::act_max);

endmodule

`default_nettype wire

/* source/tmip_frame_buf.sv */
`timescale 1ns/100ps
`default_nettype none

module tmip_frame_buf #(
  parameter int img_dim = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               pix_wr,
  input  logic [$clog2(img_dim*img_dim)-1:0] pix_addr,
  input  tmip_pkg::gray_triple_t             pix_gray,
  input  tmip_pkg::frame_op_t                frame_op,
  input  logic [$clog2(img_dim*img_dim)-1:0] rd_addr,
  output tmip_pkg::pixel_t                   rd_pixel
);

  localparam int npix = img_dim*img_dim;

  tmip_pkg::gray_triple_t planes [npix];
  tmip_pkg::pixel_t       work [npix];

  function automatic tmip_pkg::pixel_t sel_gray(
    input tmip_pkg::gray_triple_t g,
    input tmip_pkg::gray_method_e m
  );
    case (m)
      tmip_pkg::gray_avg:
        return g.avg_val;
      tmip_pkg::gray_wgt:
        return g.wgt_val;
      default:
        return g.max_val;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // grey planes, written as pixels arrive
  // ------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (pix_wr)
    begin
      planes[pix_addr] <= pix_gray;
    end
  end

  // ------------------------------------------------------------------------
  // working image, every operation finishes in one clock
  // ------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (frame_op.load)
    begin
      for (int i = 0; i < npix; i++)
      begin
        work[i] <= sel_gray(planes[i], frame_op.method);
      end
    end
    else if (frame_op.neg)
    begin
      for (int i = 0; i < npix; i++)
      begin
        work[i] <= ~work[i];
      end
    end
    else if (frame_op.flip)
    begin
      // horizontal mirror, row by row
      for (int y = 0; y < img_dim; y++)
      begin
        for (int x = 0; x < img_dim; x++)
        begin
          work[y*img_dim + x] <= work[y*img_dim + img_dim - 1 - x];
        end
      end
    end
  end

  assign rd_pixel = work[rd_addr];

  a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({frame_op.load, frame_op.neg, frame_op.flip}));

endmodule

`default_nettype wire

/* source/tmip_xcorr.sv */
`timescale 1ns/100ps
`default_nettype none

module tmip_xcorr #(
  parameter int img_dim = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               xcorr_start,
  input  tmip_pkg::tmpl_t                    tmpl,
  input  tmip_pkg::pixel_t                   rd_pixel,
  output logic [$clog2(img_dim*img_dim)-1:0] rd_addr,
  output logic                               xcorr_done,
  output logic                               out_valid,
  output logic                               out_value
);

  localparam int npix = img_dim*img_dim;
  localparam int addr_w = $clog2(npix);
  localparam int dim_w = $clog2(img_dim);
  localparam int last_bit = tmip_pkg::corr_bits - 1;

  // accumulator side
  logic              run;
  logic [dim_w-1:0]  pix_x;
  logic [dim_w-1:0]  pix_y;
  logic [1:0]        tap_x;
  logic [1:0]        tap_y;
  logic              first_tap;
  logic              step;
  logic              acc_done;
  logic              last_pix;
  logic              tap_in;
  int                row;
  int                col;
  logic [15:0]       prod;
  tmip_pkg::corr_t   acc;
  tmip_pkg::corr_t   acc_sum;

  // serializer side
  tmip_pkg::corr_t   hold;
  logic              hold_valid;
  tmip_pkg::corr_t   shift_q;
  tmip_pkg::corr_t   next_word;
  logic [4:0]        bit_cnt;
  logic [addr_w-1:0] word_cnt;
  logic              word_end;
  logic              shift_free;
  logic              load_now;

  // ------------------------------------------------------------------------
  // tap address and product, zero outside the image
  // ------------------------------------------------------------------------
  always_comb
  begin
    row = int'(pix_y) + int'(tap_y) - 1;
    col = int'(pix_x) + int'(tap_x) - 1;
    tap_in = (row >= 0) && (row < img_dim) && (col >= 0) && (col < img_dim);
    rd_addr = tap_in ? addr_w'(row*img_dim + col) : '0;
    prod = tap_in ? rd_pixel * tmpl[tap_y*3 + tap_x] : 16'd0;
  end

  assign first_tap = (tap_x == 2'd0) && (tap_y == 2'd0);
  // a new pixel only starts once the holding register is empty
  assign step = run && !(first_tap && hold_valid);
  assign acc_done = step && (tap_x == 2'd2) && (tap_y == 2'd2);
  assign acc_sum = (first_tap ? '0 : acc) + tmip_pkg::corr_t'(prod);
  assign last_pix = (pix_x == dim_w'(img_dim - 1)) && (pix_y == dim_w'(img_dim - 1));

  assign word_end = out_valid && (bit_cnt == 5'(last_bit));
  assign shift_free = !out_valid || (word_end && !hold_valid);
  assign load_now = (word_end && hold_valid) || (acc_done && shift_free);
  assign next_word = hold_valid ? hold : acc_sum;

  // ------------------------------------------------------------------------
  // pixel and tap counters
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      run   <= 1'b0;
      tap_x <= 2'd0;
      tap_y <= 2'd0;
      pix_x <= '0;
      pix_y <= '0;
    end
    else if (xcorr_start)
    begin
      run   <= 1'b1;
      tap_x <= 2'd0;
      tap_y <= 2'd0;
      pix_x <= '0;
      pix_y <= '0;
    end
    else if (step)
    begin
      if (tap_x == 2'd2)
      begin
        tap_x <= 2'd0;
        tap_y <= (tap_y == 2'd2) ? 2'd0 : tap_y + 2'd1;
      end
      else
      begin
        tap_x <= tap_x + 2'd1;
      end
      if (acc_done)
      begin
        if (last_pix)
        begin
          run <= 1'b0;
        end
        if (pix_x == dim_w'(img_dim - 1))
        begin
          pix_x <= '0;
          pix_y <= pix_y + 1'b1;
        end
        else
        begin
          pix_x <= pix_x + 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // serializer, MSB first with no gap between words
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid  <= 1'b0;
      out_value  <= 1'b0;
      bit_cnt    <= 5'd0;
      word_cnt   <= '0;
      hold_valid <= 1'b0;
      xcorr_done <= 1'b0;
    end
    else
    begin
      xcorr_done <= 1'b0;
      if (acc_done && !shift_free)
      begin
        hold_valid <= 1'b1;
      end
      else if (word_end && hold_valid)
      begin
        hold_valid <= 1'b0;
      end

      if (load_now)
      begin
        out_valid <= 1'b1;
        out_value <= next_word[last_bit];
        bit_cnt   <= 5'd0;
      end
      else if (word_end)
      begin
        out_valid <= 1'b0;
        out_value <= 1'b0;
        bit_cnt   <= 5'd0;
      end
      else if (out_valid)
      begin
        out_value <= shift_q[last_bit];
        bit_cnt   <= bit_cnt + 5'd1;
      end

      if (xcorr_start)
      begin
        word_cnt <= '0;
      end
      else if (word_end)
      begin
        word_cnt   <= word_cnt + 1'b1;
        xcorr_done <= word_cnt == addr_w'(npix - 1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (step)
    begin
      acc <= acc_sum;
    end
    if (acc_done && !shift_free)
    begin
      hold <= acc_sum;
    end
    if (load_now)
    begin
      shift_q <= next_word << 1;
    end
    else
    begin
      shift_q <= shift_q << 1;
    end
  end

  // out_valid may only fall after the last bit of the last pixel
  a_out_gapless: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(out_valid) |->
      $past(bit_cnt) == 5'(last_bit) && $past(word_cnt) == addr_w'(npix - 1));

endmodule

`default_nettype wire

/* source/tmip.sv */
`timescale 1ns/100ps
`default_nettype none

module tmip #(
  parameter int img_dim = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic             in_valid2,
  input  tmip_pkg::pixel_t image,
  input  tmip_pkg::pixel_t template,
  input  logic [2:0]       action,
  output logic             out_valid,
  output logic             out_value
);

  localparam int addr_w = $clog2(img_dim*img_dim);

  // ------------------------------------------------------------------------
  // block interconnect
  // ------------------------------------------------------------------------
  logic                   pix_wr;
  logic [addr_w-1:0]      pix_addr;
  tmip_pkg::gray_triple_t pix_gray;
  tmip_pkg::tmpl_t        tmpl;
  tmip_pkg::frame_op_t    frame_op;
  logic                   xcorr_start;
  logic                   xcorr_done;
  logic [addr_w-1:0]      rd_addr;
  tmip_pkg::pixel_t       rd_pixel;

  tmip_capture #(
    .img_dim (img_dim)
  ) i_capture (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .image    (image),
    .template (template),
    .pix_wr   (pix_wr),
    .pix_addr (pix_addr),
    .pix_gray (pix_gray),
    .tmpl     (tmpl)
  );

  tmip_action_seq i_action_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid2   (in_valid2),
    .action      (action),
    .xcorr_done  (xcorr_done),
    .frame_op    (frame_op),
    .xcorr_start (xcorr_start)
  );

  tmip_frame_buf #(
    .img_dim (img_dim)
  ) i_frame_buf (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_wr   (pix_wr),
    .pix_addr (pix_addr),
    .pix_gray (pix_gray),
    .frame_op (frame_op),
    .rd_addr  (rd_addr),
    .rd_pixel (rd_pixel)
  );

  tmip_xcorr #(
    .img_dim (img_dim)
  ) i_xcorr (
    .clk         (clk),
    .rst_n       (rst_n),
    .xcorr_start (xcorr_start),
    .tmpl        (tmpl),
    .rd_pixel    (rd_pixel),
    .rd_addr     (rd_addr),
    .xcorr_done  (xcorr_done),
    .out_valid   (out_valid),
    .out_value   (out_value)
  );

endmodule

`default_nettype wire

/* dv/tmip_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module tmip_checker #(
  parameter int img_dim = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic             in_valid2,
  input  tmip_pkg::pixel_t image,
  input  tmip_pkg::pixel_t template,
  input  logic [2:0]       action,
  input  logic             out_valid,
  input  logic             out_value,
  output int               value_errors,
  output int               proto_errors,
  output int               frames_done
);

  localparam int npix = img_dim*img_dim;
  localparam int nbits = tmip_pkg::corr_bits;

  int              rgb [3*npix];
  int              tmpl_q [9];
  logic [2:0]      acts [8];
  int              work_img [npix];
  tmip_pkg::corr_t expected [npix];
  tmip_pkg::corr_t word;
  int              byte_cnt;
  int              act_cnt;
  int              bit_idx;
  int              word_idx;
  int              run_len;

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------
  function automatic int gray_of(input int p, input int method);
    int r;
    int g;
    int b;
    int m;
    r = rgb[3*p];
    g = rgb[3*p + 1];
    b = rgb[3*p + 2];
    case (method)
      1: return (r + g + b) / 3;
      2: return r/4 + g/2 + b/4;
      default:
      begin
        m = r;
        if (g > m)
          m = g;
        if (b > m)
          m = b;
        return m;
      end
    endcase
  endfunction

  function automatic void build_expected();
    int tmp [npix];
    int last;
    int row;
    int col;
    int sum;
    last = (act_cnt < 8) ? act_cnt : 8;
    for (int p = 0; p < npix; p++)
      work_img[p] = gray_of(p, int'(acts[0]));
    for (int i = 1; i < last; i++)
    begin
      if (acts[i] == 3'd7)
        break;
      tmp = work_img;
      for (int y = 0; y < img_dim; y++)
      begin
        for (int x = 0; x < img_dim; x++)
        begin
          if (acts[i] == 3'd4)
            work_img[y*img_dim + x] = 255 - tmp[y*img_dim + x];
          else if (acts[i] == 3'd5)
            work_img[y*img_dim + x] = tmp[y*img_dim + img_dim - 1 - x];
        end
      end
    end
    // zero padding around the border
    for (int y = 0; y < img_dim; y++)
    begin
      for (int x = 0; x < img_dim; x++)
      begin
        sum = 0;
        for (int dy = 0; dy < 3; dy++)
        begin
          for (int dx = 0; dx < 3; dx++)
          begin
            row = y + dy - 1;
            col = x + dx - 1;
            if (row >= 0 && row < img_dim && col >= 0 && col < img_dim)
              sum += work_img[row*img_dim + col] * tmpl_q[dy*3 + dx];
          end
        end
        expected[y*img_dim + x] = tmip_pkg::corr_t'(sum);
      end
    end
  endfunction

  // ------------------------------------------------------------------------
  // capture and compare
  // ------------------------------------------------------------------------
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      if (out_valid !== 1'b0 || out_value !== 1'b0)
      begin
        $display("CHECK FAILED t=%0t out_valid/out_value in reset: got %b/%b expected 0/0",
          $time, out_valid, out_value);
        proto_errors++;
      end
      byte_cnt = 0;
      act_cnt = 0;
      bit_idx = 0;
      word_idx = 0;
      run_len = 0;
    end
    else
    begin
      if (in_valid)
      begin
        if (byte_cnt < 3*npix)
          rgb[byte_cnt] = int'(image);
        if (byte_cnt < 9)
          tmpl_q[byte_cnt] = int'(template);
        byte_cnt++;
      end
      else
      begin
        byte_cnt = 0;
      end
      if (in_valid2)
      begin
        if (act_cnt < 8)
          acts[act_cnt] = action;
        act_cnt++;
      end
      if (out_valid && (in_valid || in_valid2))
      begin
        $display("CHECK FAILED t=%0t out_valid during input phase: got 1 expected 0", $time);
        proto_errors++;
      end
      if (!out_valid && out_value !== 1'b0)
      begin
        $display("CHECK FAILED t=%0t out_value while idle: got %b expected 0",
          $time, out_value);
        proto_errors++;
      end
      if (out_valid)
      begin
        if (run_len == 0)
          build_expected();
        run_len++;
        word = {word[nbits-2:0], out_value};
        bit_idx++;
        if (bit_idx == nbits)
        begin
          if (word_idx < npix && word !== expected[word_idx])
          begin
            $display("CHECK FAILED t=%0t out_value pixel %0d: got %0d expected %0d",
              $time, word_idx, word, expected[word_idx]);
            value_errors++;
          end
          word_idx++;
          bit_idx = 0;
        end
      end
      else if (run_len != 0)
      begin
        if (run_len != npix*nbits)
        begin
          $display("CHECK FAILED t=%0t out_valid high cycles: got %0d expected %0d",
            $time, run_len, npix*nbits);
          proto_errors++;
        end
        frames_done++;
        run_len = 0;
        bit_idx = 0;
        word_idx = 0;
        act_cnt = 0;
      end
    end
  end

  initial
  begin
    value_errors = 0;
    proto_errors = 0;
    frames_done = 0;
  end

endmodule

`default_nettype wire

/* dv/tmip_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module tmip_tb;

  localparam int img_dim = 4;
  localparam int npix = img_dim*img_dim;
  localparam int n_directed = 8;
  localparam int n_frames = 12;
  localparam int timeout_limit = n_frames*(48 + 8 + npix*20 + 40);

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic             in_valid2;
  tmip_pkg::pixel_t image;
  tmip_pkg::pixel_t template;
  logic [2:0]       action;
  logic             out_valid;
  logic             out_value;
  int               value_errors;
  int               proto_errors;
  int               frames_done;
  int               cycles;
  logic [31:0]      rng_state = 32'd20;

  // action lists with one entry per nibble and entry 0 in the lowest
  logic [31:0] directed [n_directed] = '{
    32'h70, 32'h71, 32'h72, 32'h741, 32'h752, 32'h75540, 32'h734631, 32'h7362
  };

  tmip #(
    .img_dim (img_dim)
  ) i_tmip (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_valid2 (in_valid2),
    .image     (image),
    .template  (template),
    .action    (action),
    .out_valid (out_valid),
    .out_value (out_value)
  );

  tmip_checker #(
    .img_dim (img_dim)
  ) i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_valid2    (in_valid2),
    .image        (image),
    .template     (template),
    .action       (action),
    .out_valid    (out_valid),
    .out_value    (out_value),
    .value_errors (value_errors),
    .proto_errors (proto_errors),
    .frames_done  (frames_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int next_rand();
    rng_state = lcg_step(rng_state);
    return int'(rng_state[30:16]);
  endfunction

  // grey method and up to six middle opcodes from 3..6 before the correlation
  function automatic logic [31:0] random_list();
    logic [31:0] code;
    int n_ops;
    n_ops = next_rand() % 7;
    code = 32'(next_rand() % 3);
    for (int i = 1; i <= n_ops; i++)
      code |= 32'(3 + next_rand() % 4) << (4*i);
    code |= 32'h7 << (4*(n_ops + 1));
    return code;
  endfunction

  // ------------------------------------------------------------------------
  // one frame of RGB bytes with template and then the action list
  // ------------------------------------------------------------------------
  task automatic drive_frame(input logic [31:0] code);
    for (int i = 0; i < 3*npix; i++)
    begin
      @(negedge clk);
      in_valid = 1'b1;
      image = tmip_pkg::pixel_t'(next_rand());
      template = (i < 9) ? tmip_pkg::pixel_t'(next_rand()) : '0;
    end
    @(negedge clk);
    in_valid = 1'b0;
    image = '0;
    template = '0;
    @(negedge clk);
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk);
      in_valid2 = 1'b1;
      action = code[4*i +: 3];
      if (i > 0 && code[4*i +: 4] == 4'h7)
        break;
    end
    @(negedge clk);
    in_valid2 = 1'b0;
    action = 3'd0;
  endtask

  initial
  begin
    logic [31:0] code;
    // reset edge lands after every process waits on it
    rst_n <= 1'b0;
    in_valid = 1'b0;
    in_valid2 = 1'b0;
    image = '0;
    template = '0;
    action = 3'd0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    for (int f = 0; f < n_frames; f++)
    begin
      code = (f < n_directed) ? directed[f] : random_list();
      drive_frame(code);
      while (frames_done < f + 1)
        @(negedge clk);
      repeat (2) @(negedge clk);
    end
    $display("closing: %0d value errors, %0d protocol errors, %0d frames checked",
      value_errors, proto_errors, frames_done);
    if (value_errors == 0 && proto_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // run limit scaled by the number of frames
  initial
  begin
    cycles = 0;
    while (cycles < timeout_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: output stream never completed within %0d cycles", timeout_limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tmip.f */
source/tmip_pkg.sv
source/tmip_capture.sv
source/tmip_action_seq.sv
source/tmip_frame_buf.sv
source/tmip_xcorr.sv
source/tmip.sv
dv/tmip_checker.sv
dv/tmip_tb.sv
